/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_fight_status
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
LOG       = sim.log

SIM     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "^Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* hw/bot_input_lfsr.sv */
`timescale 1ns/100ps

module bot_input_lfsr (
    input  logic                          clk2,
    input  logic                          reset_n,
    input  logic                          game_over,
    output logic [fight_pkg::BUTTON_W-1:0] bot_buttons
);

    logic [fight_pkg::LFSR_W-1:0] lfsr_q;
    logic                         feedback;

    // taps 16,14,13,11
    assign feedback = lfsr_q[fight_pkg::LFSR_W-1] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];

    always_ff @(posedge clk2) begin
        if (reset_n) begin
            lfsr_q <= fight_pkg::BOT_SEED;
        end else begin
            lfsr_q <= {lfsr_q[fight_pkg::LFSR_W-2:0], feedback};
        end
    end

    assign bot_buttons = game_over ? '0 : lfsr_q[5:3];  // bot idles after the round

endmodule

/* hw/fight_pkg.sv */
package fight_pkg;

    localparam int DIGIT_W = 4;
    localparam logic [DIGIT_W-1:0] TIME_LAST_DIGIT = 4'd9;  // each digit runs 0..9

    localparam int REMATCH_DELAY = 30;  // cycles of ignored buttons after game over

    localparam int BUTTON_W = 3;

    localparam int LFSR_W = 16;
    localparam logic [LFSR_W-1:0] BOT_SEED = 16'd14515;

    // round timer read as two bcd digits or as one raw byte
    typedef union packed {
        struct packed {
            logic [DIGIT_W-1:0] tens;
            logic [DIGIT_W-1:0] ones;
        } digits;
        logic [2*DIGIT_W-1:0] raw;  // straight to hex_count
    } match_time_u;

endpackage

/* hw/fight_status_top.sv */
`timescale 1ns/100ps

module fight_status_top (
    input  logic                          clk2,
    input  logic                          reset_n,
    input  logic                          died1,
    input  logic                          died2,
    input  logic [fight_pkg::BUTTON_W-1:0] buttons,
    output logic [6:0]                    hexout0,
    output logic [6:0]                    hexout1,
    output logic [6:0]                    hexout2,
    output logic [6:0]                    hexout3,
    output logic [6:0]                    hexout4,
    output logic [6:0]                    hexout5,
    output logic [7:0]                    hex_count,
    output logic [fight_pkg::BUTTON_W-1:0] bot_buttons,
    output logic                          game_over,
    output logic                          menu_can_start
);

    logic                  p1_wins;
    logic                  draw;
    fight_pkg::match_time_u match_time;

    match_referee referee_i (
        .clk2       (clk2),
        .reset_n    (reset_n),
        .died1      (died1),
        .died2      (died2),
        .game_over  (game_over),
        .p1_wins    (p1_wins),
        .p2_wins    (),  // implied by the display when neither p1 nor draw
        .draw       (draw),
        .match_time (match_time)
    );

    scoreboard_display display_i (
        .game_over  (game_over),
        .p1_wins    (p1_wins),
        .draw       (draw),
        .match_time (match_time),
        .hexout0    (hexout0),
        .hexout1    (hexout1),
        .hexout2    (hexout2),
        .hexout3    (hexout3),
        .hexout4    (hexout4),
        .hexout5    (hexout5)
    );

    rematch_gate rematch_i (
        .clk2           (clk2),
        .reset_n        (reset_n),
        .game_over      (game_over),
        .buttons        (buttons),
        .menu_can_start (menu_can_start)
    );

    bot_input_lfsr bot_i (
        .clk2        (clk2),
        .reset_n     (reset_n),
        .game_over   (game_over),
        .bot_buttons (bot_buttons)
    );

    assign hex_count = match_time.raw;

endmodule

/* hw/match_referee.sv */
`timescale 1ns/100ps

module match_referee (
    input  logic                  clk2,
    input  logic                  reset_n,
    input  logic                  died1,
    input  logic                  died2,
    output logic                  game_over,
    output logic                  p1_wins,
    output logic                  p2_wins,
    output logic                  draw,
    output fight_pkg::match_time_u match_time
);

    logic time_up;

    assign time_up = (match_time.digits.tens == fight_pkg::TIME_LAST_DIGIT) &&
                     (match_time.digits.ones == fight_pkg::TIME_LAST_DIGIT);

    // knockouts win over the clock
    always_comb begin
        p1_wins = 1'b0;
        p2_wins = 1'b0;
        draw    = 1'b0;
        if (!reset_n) begin
            if (died1 && died2) begin
                draw = 1'b1;  // double ko
            end else if (died1) begin
                p2_wins = 1'b1;
            end else if (died2) begin
                p1_wins = 1'b1;
            end else if (time_up) begin
                draw = 1'b1;
            end
        end
        game_over = p1_wins | p2_wins | draw;
    end

    always_ff @(posedge clk2) begin
        if (reset_n) begin
            match_time.raw <= '0;
        end else if (!game_over) begin
            if (match_time.digits.ones == fight_pkg::TIME_LAST_DIGIT) begin
                match_time.digits.ones <= '0;
                match_time.digits.tens <= match_time.digits.tens + 1'b1;  // carry
            end else begin
                match_time.digits.ones <= match_time.digits.ones + 1'b1;
            end
        end
    end

endmodule

/* hw/rematch_gate.sv */
`timescale 1ns/100ps

module rematch_gate (
    input  logic                          clk2,
    input  logic                          reset_n,
    input  logic                          game_over,
    input  logic [fight_pkg::BUTTON_W-1:0] buttons,
    output logic                          menu_can_start
);

    logic [$clog2(fight_pkg::REMATCH_DELAY+1)-1:0] delay_cnt;
    logic [fight_pkg::BUTTON_W-1:0]                buttons_prev;
    logic                                          press_edge;

    assign press_edge = |(buttons & ~buttons_prev);  // any fresh press

    always_ff @(posedge clk2) begin
        if (reset_n) begin
            delay_cnt      <= '0;
            buttons_prev   <= '0;
            menu_can_start <= 1'b0;
        end else begin
            buttons_prev <= buttons;
            if (!game_over) begin
                delay_cnt      <= '0;
                menu_can_start <= 1'b0;
            end else if (delay_cnt < fight_pkg::REMATCH_DELAY) begin
                delay_cnt <= delay_cnt + 1'b1;  // still cooling down
            end else if (press_edge) begin
                menu_can_start <= 1'b1;  // held until the round restarts
            end
        end
    end

endmodule

/* hw/scoreboard_display.sv */
`timescale 1ns/100ps

module scoreboard_display (
    input  logic                  game_over,
    input  logic                  p1_wins,
    input  logic                  draw,
    input  fight_pkg::match_time_u match_time,
    output logic [6:0]            hexout0,
    output logic [6:0]            hexout1,
    output logic [6:0]            hexout2,
    output logic [6:0]            hexout3,
    output logic [6:0]            hexout4,
    output logic [6:0]            hexout5
);

    logic [6:0] ones_seg;
    logic [6:0] tens_seg;

    seg7_decoder ones_dec_i (
        .digit    (match_time.digits.ones),
        .segments (ones_seg)
    );

    seg7_decoder tens_dec_i (
        .digit    (match_time.digits.tens),
        .segments (tens_seg)
    );

    always_comb begin
        if (!game_over) begin
            hexout5 = seg_pkg::SEG_F;  // FIGHt
            hexout4 = seg_pkg::SEG_I;
            hexout3 = seg_pkg::SEG_G;
            hexout2 = seg_pkg::SEG_H;
            hexout1 = seg_pkg::SEG_T;
            hexout0 = seg_pkg::SEG_BLANK;
        end else begin
            if (draw) begin
                hexout5 = seg_pkg::SEG_E;
                hexout4 = seg_pkg::SEG_Q;
            end else begin
                hexout5 = seg_pkg::SEG_P;
                hexout4 = p1_wins ? seg_pkg::SEG_ONE : seg_pkg::SEG_TWO;
            end
            hexout3 = seg_pkg::SEG_DASH;
            hexout2 = tens_seg;  // frozen time
            hexout1 = ones_seg;
            hexout0 = seg_pkg::SEG_DASH;
        end
    end

endmodule

/* hw/seg7_decoder.sv */
`timescale 1ns/100ps

module seg7_decoder (
    input  logic [3:0] digit,
    output logic [6:0] segments
);

    always_comb begin
        if (digit > 4'd9) begin
            segments = seg_pkg::SEG_BLANK;  // not a decimal digit
        end else begin
            segments = seg_pkg::SEG_DIGITS[digit];
        end
    end

endmodule

/* hw/seg_pkg.sv */
package seg_pkg;

    // active low with segment a in bit 0 and g in bit 6
    localparam logic [6:0] SEG_BLANK = 7'b1111111;
    localparam logic [6:0] SEG_T     = 7'b0000111;
    localparam logic [6:0] SEG_H     = 7'b0001001;
    localparam logic [6:0] SEG_G     = 7'b0000010;
    localparam logic [6:0] SEG_I     = 7'b1001111;
    localparam logic [6:0] SEG_F     = 7'b0001110;
    localparam logic [6:0] SEG_DASH  = 7'b0111111;  // g only
    localparam logic [6:0] SEG_P     = 7'b0001100;
    localparam logic [6:0] SEG_ONE   = 7'b1001111;  // left-side one next to P
    localparam logic [6:0] SEG_TWO   = 7'b0100100;
    localparam logic [6:0] SEG_Q     = 7'b0011000;
    localparam logic [6:0] SEG_E     = 7'b0000110;

    // index 0 is the leftmost entry
    localparam logic [0:9][6:0] SEG_DIGITS = {
        7'b1000000,  // 0
        7'b1111001,
        7'b0100100,
        7'b0110000,
        7'b0011001,
        7'b0010010,
        7'b0000010,
        7'b1111000,
        7'b0000000,
        7'b0010000   // 9
    };

endpackage

/* testbench/fight_status_assertions.sv */
`timescale 1ns/100ps

module fight_status_assertions (
    input logic                           clk2,
    input logic                           reset_n,
    input logic                           game_over,
    input logic                           menu_can_start,
    input logic [fight_pkg::BUTTON_W-1:0] bot_buttons,
    input logic [7:0]                     hex_count
);

    int fail_count = 0;

    property rematch_only_after_round;
        @(posedge clk2) disable iff (reset_n)
            menu_can_start |-> game_over;
    endproperty

    property bot_muted_after_round;
        @(posedge clk2) disable iff (reset_n)
            game_over |-> (bot_buttons == '0);
    endproperty

    // frozen clock on the scoreboard
    property timer_frozen_after_round;
        @(posedge clk2) disable iff (reset_n)
            game_over |=> $stable(hex_count);
    endproperty

    rematch_chk: assert property (rematch_only_after_round)
        else begin
            fail_count++;
            $error("menu_can_start is high while game_over is low");
        end

    bot_chk: assert property (bot_muted_after_round)
        else begin
            fail_count++;
            $error("bot_buttons not zero after the round ended");
        end

    timer_chk: assert property (timer_frozen_after_round)
        else begin
            fail_count++;
            $error("hex_count moved while game_over was high");
        end

endmodule

/* testbench/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk2
);

    localparam time PERIOD = 20;

    initial begin
        clk2 = 1'b0;
    end

    always #(PERIOD / 2) clk2 = ~clk2;

endmodule

/* testbench/tb_fight_status.sv */
`timescale 1ns/100ps

module tb_fight_status;

    localparam int TIMEOUT_CYCLES = 2000;

    logic                           clk2;
    logic                           reset_n;
    logic                           died1;
    logic                           died2;
    logic [fight_pkg::BUTTON_W-1:0] buttons;
    logic [6:0]                     hexout0;
    logic [6:0]                     hexout1;
    logic [6:0]                     hexout2;
    logic [6:0]                     hexout3;
    logic [6:0]                     hexout4;
    logic [6:0]                     hexout5;
    logic [7:0]                     hex_count;
    logic [fight_pkg::BUTTON_W-1:0] bot_buttons;
    logic                           game_over;
    logic                           menu_can_start;

    logic [fight_pkg::LFSR_W-1:0]  model_lfsr;
    logic [fight_pkg::DIGIT_W-1:0] model_tens;
    logic [fight_pkg::DIGIT_W-1:0] model_ones;

    int seed = 32'h8908;
    int check_count = 0;
    int error_count = 0;
    int cycle_count = 0;

    tb_clock_gen clk_gen_i (.clk2(clk2));

    fight_status_top dut_i (
        .clk2           (clk2),
        .reset_n        (reset_n),
        .died1          (died1),
        .died2          (died2),
        .buttons        (buttons),
        .hexout0        (hexout0),
        .hexout1        (hexout1),
        .hexout2        (hexout2),
        .hexout3        (hexout3),
        .hexout4        (hexout4),
        .hexout5        (hexout5),
        .hex_count      (hex_count),
        .bot_buttons    (bot_buttons),
        .game_over      (game_over),
        .menu_can_start (menu_can_start)
    );

    bind fight_status_top fight_status_assertions assertions_i (
        .clk2           (clk2),
        .reset_n        (reset_n),
        .game_over      (game_over),
        .menu_can_start (menu_can_start),
        .bot_buttons    (bot_buttons),
        .hex_count      (hex_count)
    );

    always @(posedge clk2) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic check_eq(input string what, input logic [15:0] got, input logic [15:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("test %s done, %0d errors", name, error_count - errors_before);
    endtask

    // advance one clk2 edge and the models with it
    task automatic step_cycle;
        logic fb;
        @(posedge clk2);
        fb = model_lfsr[15] ^ model_lfsr[13] ^ model_lfsr[12] ^ model_lfsr[10];
        model_lfsr = {model_lfsr[14:0], fb};
        if (!died1 && !died2 && !(model_tens == 4'd9 && model_ones == 4'd9)) begin
            if (model_ones == 4'd9) begin
                model_ones = 4'd0;
                model_tens = model_tens + 4'd1;
            end else begin
                model_ones = model_ones + 4'd1;
            end
        end
        @(negedge clk2);
    endtask

    task automatic apply_reset;
        reset_n = 1'b1;
        died1   = 1'b0;
        died2   = 1'b0;
        buttons = '0;
        repeat (2) @(posedge clk2);
        @(negedge clk2);
        reset_n    = 1'b0;
        model_lfsr = fight_pkg::BOT_SEED;
        model_tens = 4'd0;
        model_ones = 4'd0;
    endtask

    task automatic check_glyphs(input logic [6:0] g5, input logic [6:0] g4, input logic [6:0] g3,
                                input logic [6:0] g2, input logic [6:0] g1, input logic [6:0] g0);
        check_eq("hexout5", hexout5, g5);
        check_eq("hexout4", hexout4, g4);
        check_eq("hexout3", hexout3, g3);
        check_eq("hexout2", hexout2, g2);
        check_eq("hexout1", hexout1, g1);
        check_eq("hexout0", hexout0, g0);
    endtask

    task automatic check_fight_glyphs;
        check_glyphs(seg_pkg::SEG_F, seg_pkg::SEG_I, seg_pkg::SEG_G,
                     seg_pkg::SEG_H, seg_pkg::SEG_T, seg_pkg::SEG_BLANK);
    endtask

    task automatic test_reset;
        int errs;
        errs = error_count;
        apply_reset();
        check_eq("hex_count", hex_count, 8'h00);
        check_eq("game_over", game_over, 1'b0);
        check_eq("menu_can_start", menu_can_start, 1'b0);
        check_fight_glyphs();
        report_test("reset", errs);
    endtask

    task automatic test_timer;
        int errs;
        logic [7:0] exp;
        errs = error_count;
        apply_reset();
        for (int n = 1; n < 99; n++) begin
            step_cycle();
            exp = 8'(((n / 10) << 4) | (n % 10));  // bcd of the cycle count
            check_eq("hex_count", hex_count, exp);
            check_eq("game_over", game_over, 1'b0);
        end
        step_cycle();
        check_eq("game_over at 99", game_over, 1'b1);
        check_glyphs(seg_pkg::SEG_E, seg_pkg::SEG_Q, seg_pkg::SEG_DASH,
                     seg_pkg::SEG_DIGITS[9], seg_pkg::SEG_DIGITS[9], seg_pkg::SEG_DASH);
        repeat (5) begin
            step_cycle();
            check_eq("hex_count held", hex_count, 8'h99);
        end
        report_test("timer", errs);
    endtask

    task automatic knockout_case(input logic d1, input logic d2,
                                 input logic [6:0] g5, input logic [6:0] g4);
        int n;
        logic [7:0] frozen;
        apply_reset();
        n = 1 + int'($unsigned($random(seed)) % 90);
        repeat (n) step_cycle();
        died1 = d1;
        died2 = d2;
        #5;  // outcome is combinational
        frozen = {model_tens, model_ones};
        check_eq("game_over on knockout", game_over, 1'b1);
        check_glyphs(g5, g4, seg_pkg::SEG_DASH, seg_pkg::SEG_DIGITS[model_tens],
                     seg_pkg::SEG_DIGITS[model_ones], seg_pkg::SEG_DASH);
        check_eq("hex_count at knockout", hex_count, frozen);
        repeat (3) step_cycle();
        check_eq("hex_count frozen", hex_count, frozen);
    endtask

    task automatic test_knockouts;
        int errs;
        errs = error_count;
        knockout_case(1'b1, 1'b0, seg_pkg::SEG_P, seg_pkg::SEG_TWO);
        knockout_case(1'b0, 1'b1, seg_pkg::SEG_P, seg_pkg::SEG_ONE);
        knockout_case(1'b1, 1'b1, seg_pkg::SEG_E, seg_pkg::SEG_Q);
        report_test("knockouts", errs);
    endtask

    task automatic test_rematch;
        int errs;
        int waited;
        errs = error_count;
        apply_reset();
        repeat (3) step_cycle();
        died2 = 1'b1;
        for (int i = 0; i < fight_pkg::REMATCH_DELAY; i++) begin
            if (i < 26) begin
                buttons = (i % 4 >= 2) ? 3'b001 : 3'b000;  // short taps
            end else begin
                buttons = 3'b010;  // held across the end of the delay
            end
            step_cycle();
            check_eq("menu_can_start in delay", menu_can_start, 1'b0);
        end
        repeat (4) begin
            step_cycle();
            check_eq("menu_can_start on held button", menu_can_start, 1'b0);
        end
        buttons = 3'b000;
        step_cycle();
        check_eq("menu_can_start after release", menu_can_start, 1'b0);
        buttons = 3'b100;
        waited = 0;
        while (!menu_can_start && waited < 2) begin
            step_cycle();
            waited++;
        end
        check_eq("menu_can_start after fresh press", menu_can_start, 1'b1);
        buttons = 3'b000;
        repeat (5) begin
            step_cycle();
            check_eq("menu_can_start stays high", menu_can_start, 1'b1);
        end
        check_eq("game_over during rematch", game_over, 1'b1);
        report_test("rematch", errs);
    endtask

    task automatic test_bot;
        int errs;
        errs = error_count;
        apply_reset();
        check_eq("bot_buttons", bot_buttons, model_lfsr[5:3]);
        repeat (40) begin
            step_cycle();
            check_eq("bot_buttons", bot_buttons, model_lfsr[5:3]);
        end
        died1 = 1'b1;
        #5;
        check_eq("bot_buttons muted", bot_buttons, 3'b000);
        repeat (4) begin
            step_cycle();
            check_eq("bot_buttons muted", bot_buttons, 3'b000);
        end
        report_test("bot", errs);
    endtask

    initial begin
        reset_n    = 1'b1;
        died1      = 1'b0;
        died2      = 1'b0;
        buttons    = '0;
        model_lfsr = fight_pkg::BOT_SEED;
        model_tens = 4'd0;
        model_ones = 4'd0;
        @(negedge clk2);
        test_reset();
        test_timer();
        test_knockouts();
        test_rematch();
        test_bot();
        $display("checks: %0d, errors: %0d, assertion failures: %0d, cycles: %0d",
                 check_count, error_count, dut_i.assertions_i.fail_count, cycle_count);
        if (error_count == 0 && dut_i.assertions_i.fail_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
hw/fight_pkg.sv
hw/seg_pkg.sv
hw/seg7_decoder.sv
hw/match_referee.sv
hw/scoreboard_display.sv
hw/rematch_gate.sv
hw/bot_input_lfsr.sv
hw/fight_status_top.sv
testbench/tb_clock_gen.sv
testbench/fight_status_assertions.sv
testbench/tb_fight_status.sv
